// File: oflow_pkg.sv
package oflow_pkg;

	// Task id and physical core id width
	localparam int KEY_WIDTH = 4;

	// Number of tracked tasks
	localparam int KEY_SIZE = 16;

	// Reference counter and maximum-count width
	localparam int COUNT_WIDTH = 8;

	// Processor bus widths
	localparam int DATA_WIDTH = 32;
	localparam int ADDR_WIDTH = 32;

	// Base of the event window on the processor bus
	localparam logic [ADDR_WIDTH-1:0] OFLOW_OFFSET = 32'h0800_0000;

	// Physical id lands at this bit of the address
	localparam int ID_SHIFT = 20;

	// Constant added to every posted event word
	localparam logic [9:0] EVENT_BASE = 10'h200;

	// One event record is {physical id, task id}
	localparam int EVENT_WIDTH = 2 * KEY_WIDTH;

	// Depth of each event queue
	localparam int FIFO_DEPTH = KEY_SIZE / 2;

	// Bus writer states
	typedef enum logic [2:0] {
		IDLE,
		OVF_READ,
		UNF_READ,
		OVF_LATCH,
		UNF_LATCH,
		POST
	} writer_state_t;

endpackage

// File: count_decoder.sv
`timescale 1ns/1ps

module count_decoder (
	input  logic                          count_inc,
	input  logic                          count_dec,
	input  logic [oflow_pkg::KEY_WIDTH-1:0] count_inc_task_id,
	input  logic [oflow_pkg::KEY_WIDTH-1:0] count_dec_task_id,
	input  logic                          count_inc_logical_core_id,
	output logic                          inc_0,
	output logic                          inc_1,
	output logic                          dec_0,
	output logic                          dec_1
);

	logic same_task;
	logic inc_core_0;
	logic inc_core_1;
	logic clash;

	assign same_task = (count_inc_task_id == count_dec_task_id);

	// Which logical core the inc strobe targets
	assign inc_core_0 = count_inc & ~count_inc_logical_core_id;
	assign inc_core_1 = count_inc & count_inc_logical_core_id;

	// An inc and a dec on one task cancel out
	assign clash = count_dec & same_task;

	assign inc_0 = inc_core_0 & ~clash;
	assign inc_1 = inc_core_1 & ~clash;

	// Only the incrementing core loses its decrement, the other bank still counts down
	assign dec_0 = count_dec & ~(inc_core_0 & same_task);
	assign dec_1 = count_dec & ~(inc_core_1 & same_task);

endmodule

// File: task_counters.sv
`timescale 1ns/1ps

module task_counters (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          inc_0,
	input  logic                          inc_1,
	input  logic                          dec_0,
	input  logic                          dec_1,
	input  logic                          reset_task,
	input  logic [oflow_pkg::KEY_WIDTH-1:0] inc_task,
	input  logic [oflow_pkg::KEY_WIDTH-1:0] dec_task,
	input  logic                          csr_maxcount_write,
	input  logic [oflow_pkg::KEY_WIDTH+oflow_pkg::COUNT_WIDTH-1:0] csr_maxcount_data,
	output logic                          overflow,
	output logic                          underflow
);

	import oflow_pkg::*;

	logic [COUNT_WIDTH-1:0] maxcount [KEY_SIZE];
	logic [KEY_WIDTH-1:0]   csr_task;
	logic [COUNT_WIDTH-1:0] csr_value;
	logic [COUNT_WIDTH-1:0] max_inc;
	logic [COUNT_WIDTH-1:0] limit;
	logic [1:0]             inc_en;
	logic [1:0]             dec_en;
	logic [1:0]             core_ovf;
	logic [1:0]             core_unf;

	assign inc_en = {inc_1, inc_0};
	assign dec_en = {dec_1, dec_0};

	// Task id sits above the count value
	assign csr_task  = csr_maxcount_data[KEY_WIDTH+COUNT_WIDTH-1 -: KEY_WIDTH];
	assign csr_value = csr_maxcount_data[COUNT_WIDTH-1:0];

	assign max_inc = maxcount[inc_task];

	// A zero maximum means no limit, so only stop at the top of the range
	assign limit = (max_inc == '0) ? '1 : max_inc;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < KEY_SIZE; i++) begin
				maxcount[i] <= '0;
			end
		end else if (csr_maxcount_write) begin
			maxcount[csr_task] <= csr_value;
		end
	end

	for (genvar c = 0; c < 2; c++) begin : g_core
		logic [COUNT_WIDTH-1:0] count [KEY_SIZE];
		logic [COUNT_WIDTH-1:0] cnt_inc;
		logic [COUNT_WIDTH-1:0] cnt_dec;
		logic [COUNT_WIDTH-1:0] cnt_next;

		// Combinational read, written back at the same edge
		assign cnt_inc  = count[inc_task];
		assign cnt_dec  = count[dec_task];
		assign cnt_next = (cnt_inc < limit) ? cnt_inc + 1'b1 : limit;

		// Fires on the inc that lands on the maximum
		assign core_ovf[c] = inc_en[c] && (max_inc != '0) &&
			(cnt_inc != max_inc) && (cnt_next == max_inc);

		assign core_unf[c] = dec_en[c] && (cnt_dec == COUNT_WIDTH'(1));

		always_ff @(posedge clk or posedge reset) begin
			if (reset) begin
				for (int i = 0; i < KEY_SIZE; i++) begin
					count[i] <= '0;
				end
			end else begin
				if (inc_en[c]) begin
					count[inc_task] <= cnt_next;
				end
				// reset_task wins over the dec and over an inc on the same task
				if (reset_task) begin
					count[dec_task] <= '0;
				end else if (dec_en[c] && (cnt_dec != '0)) begin
					count[dec_task] <= cnt_dec - 1'b1;
				end
			end
		end

		// Stored count against the current maximum of the inc task
		a_count_le_max : assert property (@(posedge clk) disable iff (reset)
			(max_inc != '0) |-> (cnt_inc <= max_inc))
			else $error("task_counters: core %0d count above maximum", c);
	end

	assign overflow = |core_ovf;

	// Both banks must drain together
	assign underflow = (&core_unf) & ~reset_task;

endmodule

// File: overflow_tracker.sv
`timescale 1ns/1ps

module overflow_tracker (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              overflow,
	input  logic                              underflow,
	input  logic                              reset_task,
	input  logic [oflow_pkg::KEY_WIDTH-1:0]   inc_task,
	input  logic [oflow_pkg::KEY_WIDTH-1:0]   dec_task,
	input  logic [oflow_pkg::KEY_WIDTH-1:0]   inc_physical_id,
	input  logic [oflow_pkg::KEY_SIZE-1:0]    checkin_in,
	output logic                              ovf_push,
	output logic [oflow_pkg::EVENT_WIDTH-1:0] ovf_record,
	output logic                              unf_push,
	output logic [oflow_pkg::EVENT_WIDTH-1:0] unf_record,
	output logic [oflow_pkg::KEY_SIZE-1:0]    checkin_out
);

	import oflow_pkg::*;

	logic [KEY_SIZE-1:0]  status;
	logic [KEY_WIDTH-1:0] id_table [KEY_SIZE];
	logic                 release_task;

	// First overflow only, later ones are already reported
	assign ovf_push   = overflow & ~status[inc_task];
	assign ovf_record = {inc_physical_id, inc_task};

	// Underflow matters only on a task that overflowed
	assign unf_push   = underflow & status[dec_task];
	assign unf_record = {id_table[dec_task], dec_task};

	assign release_task = unf_push | reset_task;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			status <= '0;
		end else begin
			if (ovf_push) begin
				status[inc_task] <= 1'b1;
			end
			if (release_task) begin
				status[dec_task] <= 1'b0;
			end
		end
	end

	// Physical core that caused the overflow
	always_ff @(posedge clk) begin
		if (ovf_push) begin
			id_table[inc_task] <= inc_physical_id;
		end
		if (release_task) begin
			id_table[dec_task] <= '0;
		end
	end

	// Overflowed tasks may not check in
	assign checkin_out = checkin_in & ~status;

endmodule

// File: event_fifo.sv
`timescale 1ns/1ps

module event_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 8
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             push,
	input  logic [WIDTH-1:0] wdata,
	input  logic             pop,
	output logic [WIDTH-1:0] rdata,
	output logic             empty,
	output logic             full
);

	logic [WIDTH-1:0]         mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH):0]   used;

	assign empty = (used == '0);
	assign full  = (used == DEPTH);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used   <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   used <= used + 1'b1;
				2'b01:   used <= used - 1'b1;
				default: used <= used;
			endcase
		end
	end

	// Storage and read data
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wdata;
		end
		if (pop) begin
			rdata <= mem[rd_ptr];
		end
	end

	a_no_overrun : assert property (@(posedge clk) disable iff (reset) push |-> !full)
		else $error("event_fifo: push while full");
	a_no_underrun : assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
		else $error("event_fifo: pop while empty");

endmodule

// File: oflow_writer.sv
`timescale 1ns/1ps

module oflow_writer (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              ovf_empty,
	input  logic                              unf_empty,
	input  logic [oflow_pkg::EVENT_WIDTH-1:0] ovf_rdata,
	input  logic [oflow_pkg::EVENT_WIDTH-1:0] unf_rdata,
	input  logic                              oflow_waitrequest,
	output logic                              ovf_pop,
	output logic                              unf_pop,
	output logic                              oflow_write,
	output logic [oflow_pkg::ADDR_WIDTH-1:0]  oflow_address,
	output logic [oflow_pkg::DATA_WIDTH-1:0]  oflow_writedata
);

	import oflow_pkg::*;

	writer_state_t state;
	writer_state_t state_next;

	// Kind bit on top of the record, 1 for overflow
	logic [EVENT_WIDTH:0] event_q;

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				// Overflow queue has priority
				if (!ovf_empty) begin
					state_next = OVF_READ;
				end else if (!unf_empty) begin
					state_next = UNF_READ;
				end
			end
			OVF_READ:  state_next = OVF_LATCH;
			UNF_READ:  state_next = UNF_LATCH;
			OVF_LATCH: state_next = POST;
			UNF_LATCH: state_next = POST;
			POST: begin
				if (!oflow_waitrequest) begin
					state_next = IDLE;
				end
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// FIFO read data is valid in the LATCH state
	always_ff @(posedge clk) begin
		if (state == OVF_LATCH) begin
			event_q <= {1'b1, ovf_rdata};
		end else if (state == UNF_LATCH) begin
			event_q <= {1'b0, unf_rdata};
		end
	end

	assign ovf_pop = (state == OVF_READ);
	assign unf_pop = (state == UNF_READ);

	assign oflow_write   = (state == POST);
	assign oflow_address = OFLOW_OFFSET +
		(ADDR_WIDTH'(event_q[EVENT_WIDTH-1 -: KEY_WIDTH]) << ID_SHIFT);
	assign oflow_writedata = DATA_WIDTH'(EVENT_BASE) + DATA_WIDTH'(event_q);

endmodule

// File: oflow_top.sv
`timescale 1ns/1ps

module oflow_top (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 count_inc,
	input  logic [oflow_pkg::KEY_WIDTH-1:0]      count_inc_task_id,
	input  logic                                 count_inc_logical_core_id,
	input  logic [oflow_pkg::KEY_WIDTH-1:0]      count_inc_physical_core_id,
	input  logic                                 count_dec,
	input  logic [oflow_pkg::KEY_WIDTH-1:0]      count_dec_task_id,
	input  logic                                 reset_task,
	input  logic                                 csr_maxcount_write,
	input  logic [oflow_pkg::KEY_WIDTH+oflow_pkg::COUNT_WIDTH-1:0] csr_maxcount_data,
	input  logic [oflow_pkg::KEY_SIZE-1:0]       checkin_in,
	input  logic                                 oflow_waitrequest,
	output logic [oflow_pkg::KEY_SIZE-1:0]       checkin_out,
	output logic                                 oflow_write,
	output logic [oflow_pkg::ADDR_WIDTH-1:0]     oflow_address,
	output logic [oflow_pkg::DATA_WIDTH-1:0]     oflow_writedata
);

	import oflow_pkg::*;

	logic                   inc_0;
	logic                   inc_1;
	logic                   dec_0;
	logic                   dec_1;
	logic                   overflow;
	logic                   underflow;
	logic                   ovf_push;
	logic                   unf_push;
	logic [EVENT_WIDTH-1:0] ovf_record;
	logic [EVENT_WIDTH-1:0] unf_record;
	logic                   ovf_pop;
	logic                   unf_pop;
	logic [EVENT_WIDTH-1:0] ovf_rdata;
	logic [EVENT_WIDTH-1:0] unf_rdata;
	logic                   ovf_empty;
	logic                   unf_empty;

	count_decoder u_decoder (
		.count_inc                 (count_inc),
		.count_dec                 (count_dec),
		.count_inc_task_id         (count_inc_task_id),
		.count_dec_task_id         (count_dec_task_id),
		.count_inc_logical_core_id (count_inc_logical_core_id),
		.inc_0 (inc_0),
		.inc_1 (inc_1),
		.dec_0 (dec_0),
		.dec_1 (dec_1)
	);

	task_counters u_counters (
		.clk (clk), .reset (reset),
		.inc_0 (inc_0), .inc_1 (inc_1), .dec_0 (dec_0), .dec_1 (dec_1),
		.reset_task         (reset_task),
		.inc_task           (count_inc_task_id),
		.dec_task           (count_dec_task_id),
		.csr_maxcount_write (csr_maxcount_write),
		.csr_maxcount_data  (csr_maxcount_data),
		.overflow           (overflow),
		.underflow          (underflow)
	);

	overflow_tracker u_tracker (
		.clk (clk), .reset (reset),
		.overflow (overflow), .underflow (underflow), .reset_task (reset_task),
		.inc_task        (count_inc_task_id),
		.dec_task        (count_dec_task_id),
		.inc_physical_id (count_inc_physical_core_id),
		.checkin_in      (checkin_in),
		.ovf_push (ovf_push), .ovf_record (ovf_record),
		.unf_push (unf_push), .unf_record (unf_record),
		.checkin_out     (checkin_out)
	);

	event_fifo #(.WIDTH(EVENT_WIDTH), .DEPTH(FIFO_DEPTH)) ovf_fifo (
		.clk (clk), .reset (reset),
		.push (ovf_push), .wdata (ovf_record), .pop (ovf_pop),
		.rdata (ovf_rdata), .empty (ovf_empty), .full ()
	);

	event_fifo #(.WIDTH(EVENT_WIDTH), .DEPTH(FIFO_DEPTH)) unf_fifo (
		.clk (clk), .reset (reset),
		.push (unf_push), .wdata (unf_record), .pop (unf_pop),
		.rdata (unf_rdata), .empty (unf_empty), .full ()
	);

	oflow_writer u_writer (
		.clk (clk), .reset (reset),
		.ovf_empty (ovf_empty), .unf_empty (unf_empty),
		.ovf_rdata (ovf_rdata), .unf_rdata (unf_rdata),
		.oflow_waitrequest (oflow_waitrequest),
		.ovf_pop (ovf_pop), .unf_pop (unf_pop),
		.oflow_write     (oflow_write),
		.oflow_address   (oflow_address),
		.oflow_writedata (oflow_writedata)
	);

endmodule

// File: tb_oflow.sv
`timescale 1ns/1ps

module tb_oflow;

	localparam int NSTEPS = 30;

	typedef enum {OP_MAX, OP_INC, OP_DEC, OP_INCDEC, OP_RST, OP_IDLE} op_t;

	typedef struct {
		op_t         op;
		logic [3:0]  inc_task;
		logic [3:0]  dec_task;
		logic        core;
		logic [3:0]  phys;
		logic [7:0]  value;
		logic [15:0] cin;
		logic [15:0] cout;
	} step_t;

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	logic        count_inc = 1'b0;
	logic [3:0]  count_inc_task_id = '0;
	logic        count_inc_logical_core_id = 1'b0;
	logic [3:0]  count_inc_physical_core_id = '0;
	logic        count_dec = 1'b0;
	logic [3:0]  count_dec_task_id = '0;
	logic        reset_task = 1'b0;
	logic        csr_maxcount_write = 1'b0;
	logic [11:0] csr_maxcount_data = '0;
	logic [15:0] checkin_in = '0;
	logic        oflow_waitrequest = 1'b0;
	logic [15:0] checkin_out;
	logic        oflow_write;
	logic [31:0] oflow_address;
	logic [31:0] oflow_writedata;

	step_t       steps [NSTEPS];
	int          n_steps = 0;
	int          cycle = 0;
	int          value_errors = 0;
	int          protocol_errors = 0;
	logic [31:0] lfsr = 32'hdb35;

	// Reference model state
	int          cnt [2][16];
	int          maxc [16];
	bit          status [16];
	logic [3:0]  id_of [16];
	logic [63:0] ovf_q [$];
	int          ovf_time [$];
	logic [63:0] unf_q [$];

	// Write seen stalled at the previous negedge
	logic        held = 1'b0;
	logic [31:0] held_addr;
	logic [31:0] held_data;

	oflow_top UUT (.*);

	always #10 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR bit per cycle decides waitrequest
	always @(posedge clk) begin
		#2;
		lfsr = lfsr_next(lfsr);
		oflow_waitrequest = lfsr[0];
	end

	task automatic value_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		value_errors++;
	endtask

	task automatic protocol_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		protocol_errors++;
	endtask

	task automatic add_step(input op_t op, input logic [3:0] it, input logic [3:0] dt,
		input logic core, input logic [3:0] phys, input logic [7:0] value,
		input logic [15:0] cin, input logic [15:0] cout);
		steps[n_steps] = '{op, it, dt, core, phys, value, cin, cout};
		n_steps++;
	endtask

	task automatic expect_event(input bit kind, input logic [3:0] phys, input logic [3:0] tsk);
		logic [31:0] addr;
		logic [31:0] data;
		addr = 32'h0800_0000 + ({28'd0, phys} << 20);
		data = 32'h200 + {23'd0, kind, phys, tsk};
		if (kind) begin
			ovf_q.push_back({addr, data});
			// FIFO push lands at the next edge
			ovf_time.push_back(cycle + 1);
		end else begin
			unf_q.push_back({addr, data});
		end
	endtask

	task automatic apply_model(input step_t s);
		bit       inc_on;
		bit       dec_on;
		bit       same;
		bit       ovf;
		bit       unf;
		bit [1:0] dec_en;
		int       top;
		inc_on = (s.op == OP_INC) || (s.op == OP_INCDEC);
		dec_on = (s.op == OP_DEC) || (s.op == OP_INCDEC);
		same = inc_on && dec_on && (s.inc_task == s.dec_task);
		ovf = 1'b0;
		if (s.op == OP_MAX) begin
			maxc[s.inc_task] = s.value;
		end
		// A cancelled inc changes nothing
		if (inc_on && !same) begin
			top = (maxc[s.inc_task] == 0) ? 255 : maxc[s.inc_task];
			if (cnt[s.core][s.inc_task] < top) begin
				cnt[s.core][s.inc_task]++;
				ovf = (cnt[s.core][s.inc_task] == maxc[s.inc_task]);
			end
		end
		// The incrementing core loses its dec on a shared task
		dec_en[0] = dec_on && !(same && s.core == 1'b0);
		dec_en[1] = dec_on && !(same && s.core == 1'b1);
		unf = (dec_en == 2'b11) && (cnt[0][s.dec_task] == 1) && (cnt[1][s.dec_task] == 1);
		if (s.op == OP_RST) begin
			cnt[0][s.dec_task] = 0;
			cnt[1][s.dec_task] = 0;
			status[s.dec_task] = 1'b0;
		end else begin
			for (int k = 0; k < 2; k++) begin
				if (dec_en[k] && cnt[k][s.dec_task] > 0) begin
					cnt[k][s.dec_task]--;
				end
			end
		end
		if (ovf && !status[s.inc_task]) begin
			status[s.inc_task] = 1'b1;
			id_of[s.inc_task] = s.phys;
			expect_event(1'b1, s.phys, s.inc_task);
		end
		if (unf && status[s.dec_task]) begin
			expect_event(1'b0, id_of[s.dec_task], s.dec_task);
			status[s.dec_task] = 1'b0;
		end
	endtask

	task automatic drive(input step_t s);
		count_inc = (s.op == OP_INC) || (s.op == OP_INCDEC);
		count_dec = (s.op == OP_DEC) || (s.op == OP_INCDEC);
		count_inc_task_id = s.inc_task;
		count_inc_logical_core_id = s.core;
		count_inc_physical_core_id = s.phys;
		count_dec_task_id = s.dec_task;
		reset_task = (s.op == OP_RST);
		csr_maxcount_write = (s.op == OP_MAX);
		csr_maxcount_data = {s.inc_task, s.value};
		checkin_in = s.cin;
	endtask

	task automatic match_write();
		logic [63:0] exp;
		bit          found;
		found = 1'b0;
		if (oflow_writedata[8] && ovf_q.size() > 0) begin
			exp = ovf_q.pop_front();
			void'(ovf_time.pop_front());
			found = 1'b1;
		end else if (!oflow_writedata[8] && unf_q.size() > 0) begin
			exp = unf_q.pop_front();
			found = 1'b1;
		end
		assert (found) else protocol_error("bus write with no matching expected event");
		if (found) begin
			assert (oflow_address == exp[63:32])
				else value_mismatch("oflow_address", oflow_address, exp[63:32]);
			assert (oflow_writedata == exp[31:0])
				else value_mismatch("oflow_writedata", oflow_writedata, exp[31:0]);
		end
	endtask

	// Bus monitor, the write is taken at the next edge when waitrequest is low
	always @(negedge clk) begin
		if (!reset) begin
			if (held) begin
				assert (oflow_write) else protocol_error("write dropped under waitrequest");
				assert (oflow_address == held_addr)
					else value_mismatch("oflow_address", oflow_address, held_addr);
				assert (oflow_writedata == held_data)
					else value_mismatch("oflow_writedata", oflow_writedata, held_data);
			end else if (oflow_write && !oflow_writedata[8]) begin
				// Writer chose this event two edges before the write began
				assert (ovf_time.size() == 0 || ovf_time[0] > cycle - 3)
					else protocol_error("underflow posted while an overflow event waited");
			end
			if (oflow_write && !oflow_waitrequest) begin
				match_write();
			end
			held = oflow_write && oflow_waitrequest;
			held_addr = oflow_address;
			held_data = oflow_writedata;
		end
	end

	task automatic build_table();
		// op, inc task, dec task, core, phys id, value, checkin_in, checkin_out
		add_step(OP_MAX,    3, 0, 0, 0, 3, 16'hffff, 16'hffff);
		add_step(OP_MAX,    6, 0, 0, 0, 2, 16'hffff, 16'hffff);
		// Core 0 takes task 3 up to its maximum
		add_step(OP_INC,    3, 0, 0, 5, 0, 16'hffff, 16'hffff);
		add_step(OP_INC,    3, 0, 0, 5, 0, 16'hffff, 16'hffff);
		add_step(OP_INC,    3, 0, 0, 5, 0, 16'hffff, 16'hffff);
		add_step(OP_IDLE,   0, 0, 0, 0, 0, 16'hffff, 16'hfff7);
		add_step(OP_INC,    3, 0, 0, 5, 0, 16'hffff, 16'hfff7);
		// Core 1 reaching the maximum reports nothing new
		add_step(OP_INC,    3, 0, 1, 9, 0, 16'hffff, 16'hfff7);
		add_step(OP_INC,    3, 0, 1, 9, 0, 16'hffff, 16'hfff7);
		add_step(OP_INC,    3, 0, 1, 9, 0, 16'hffff, 16'hfff7);
		add_step(OP_DEC,    0, 3, 0, 0, 0, 16'hffff, 16'hfff7);
		add_step(OP_DEC,    0, 3, 0, 0, 0, 16'hffff, 16'hfff7);
		add_step(OP_DEC,    0, 3, 0, 0, 0, 16'hffff, 16'hfff7);
		add_step(OP_IDLE,   0, 0, 0, 0, 0, 16'h5a5a, 16'h5a5a);
		add_step(OP_DEC,    0, 3, 0, 0, 0, 16'hffff, 16'hffff);
		// Same-task inc and dec cancel, so task 6 overflows one inc later
		add_step(OP_INC,    6, 0, 0, 2, 0, 16'hffff, 16'hffff);
		add_step(OP_INCDEC, 6, 6, 0, 2, 0, 16'hffff, 16'hffff);
		add_step(OP_INC,    6, 0, 0, 2, 0, 16'hffff, 16'hffff);
		add_step(OP_IDLE,   0, 0, 0, 0, 0, 16'hffff, 16'hffbf);
		add_step(OP_RST,    0, 6, 0, 0, 0, 16'hffff, 16'hffbf);
		add_step(OP_IDLE,   0, 0, 0, 0, 0, 16'hffff, 16'hffff);
		add_step(OP_INC,    6, 0, 0, 2, 0, 16'hffff, 16'hffff);
		add_step(OP_INC,    6, 0, 0, 4, 0, 16'hffff, 16'hffff);
		// Load both queues in one cycle
		add_step(OP_INC,    6, 0, 1, 4, 0, 16'hffff, 16'hffbf);
		add_step(OP_INCDEC, 6, 6, 1, 4, 0, 16'hffff, 16'hffbf);
		add_step(OP_INC,    3, 0, 1, 7, 0, 16'hffff, 16'hffbf);
		add_step(OP_INC,    3, 0, 1, 7, 0, 16'hffff, 16'hffbf);
		add_step(OP_INCDEC, 3, 6, 1, 7, 0, 16'hffff, 16'hffbf);
		add_step(OP_IDLE,   0, 0, 0, 0, 0, 16'hffff, 16'hfff7);
		add_step(OP_IDLE,   0, 0, 0, 0, 0, 16'hffff, 16'hfff7);
	endtask

	initial begin
		build_table();
		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;
		for (int i = 0; i < NSTEPS; i++) begin
			@(posedge clk);
			#2;
			drive(steps[i]);
			apply_model(steps[i]);
			@(negedge clk);
			assert (checkin_out == steps[i].cout)
				else value_mismatch("checkin_out", checkin_out, steps[i].cout);
		end
		// Let the writer drain what the model still expects
		while (ovf_q.size() > 0 || unf_q.size() > 0) begin
			@(posedge clk);
		end
		repeat (6) @(posedge clk);
		$display("Errors: %0d value mismatches, %0d protocol errors",
			value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(NSTEPS * 40 * 20);
		$display("Timeout: expected bus writes never arrived within %0d cycles", NSTEPS * 40);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: all.f
oflow_pkg.sv
count_decoder.sv
task_counters.sv
overflow_tracker.sv
event_fifo.sv
oflow_writer.sv
oflow_top.sv
tb_oflow.sv
